//--- fp_adder.f
+incdir+verification
verilog/fp_add_pkg.sv
verilog/fp_sum_if.sv
verilog/fp_align_add.sv
verilog/fp_shift_encoder.sv
verilog/fp_normalize.sv
verilog/fp_adder_top.sv
verification/fp_adder_asserts.sv
verification/fp_adder_tb.sv

//--- verification/fp_adder_model.svh
`ifndef FP_ADDER_MODEL_SVH
`define FP_ADDER_MODEL_SVH

// Expected FP32 sum, truncating, normal operands only
function automatic logic [31:0] model_fp_add(input fp32_t x, input fp32_t y);
    logic [23:0] mx;
    logic [23:0] my;
    logic        x_big;
    logic        big_sign;
    int          big_exp;
    logic [23:0] big_mant;
    logic [23:0] small_mant;
    int          diff;
    logic [24:0] s;
    logic [24:0] norm;
    int          lead;
    int          e;
    shift_code_t code;
    fp32_t       r;

    // Hidden one, exponent 0 reads as zero
    mx = (x.exp != 8'd0) ? {1'b1, x.frac} : 24'd0;
    my = (y.exp != 8'd0) ? {1'b1, y.frac} : 24'd0;

    // Larger by exponent, ties by mantissa
    x_big      = (x.exp > y.exp) || (x.exp == y.exp && mx >= my);
    big_sign   = x_big ? x.sign : y.sign;
    big_exp    = x_big ? int'(x.exp) : int'(y.exp);
    big_mant   = x_big ? mx : my;
    small_mant = x_big ? my : mx;
    diff       = x_big ? int'(x.exp) - int'(y.exp) : int'(y.exp) - int'(x.exp);

    // Alignment drops the shifted-out bits
    small_mant = (diff >= 25) ? 24'd0 : (small_mant >> diff);

    if (x.sign == y.sign) begin
        s = {1'b0, big_mant} + {1'b0, small_mant};
    end else begin
        s = {1'b0, big_mant} - {1'b0, small_mant};
    end

    // Leading one position as a shift code
    lead = 0;
    for (int k = 0; k < 24; k++) begin
        if (s[k]) begin
            lead = k;
        end
    end
    if (s == 25'd0) begin
        code = ZERO_CODE;
    end else if (s[24]) begin
        code = SHIFT_RIGHT_CODE;
    end else begin
        code = shift_code_t'(23 - lead);
    end

    if (code == ZERO_CODE) begin
        return 32'd0;
    end
    if (code == SHIFT_RIGHT_CODE) begin
        norm = s >> 1;
        e    = big_exp + 1;
    end else begin
        norm = s << code;
        e    = big_exp - int'(code);
    end

    // Exponent limits after normalization
    r.sign = big_sign;
    r.exp  = exp_t'(e);
    r.frac = norm[22:0];
    if (e <= 0) begin
        r = '0;
    end else if (e >= 255) begin
        r.exp  = EXP_MAX;
        r.frac = '0;
    end
    return r;
endfunction

`endif

//--- verification/fp_adder_tb.sv
`timescale 1ns/100ps

module fp_adder_tb;

    import fp_add_pkg::*;

    `include "fp_adder_model.svh"

    localparam int NUM_TXN    = 3000;
    // Generous bound, about one valid every 1.33 cycles
    localparam int MAX_CYCLES = NUM_TXN * 2 + 100;

    logic        clk;
    logic        rstn;
    logic        in_valid;
    logic [31:0] a;
    logic [31:0] b;
    logic        out_valid;
    logic [31:0] result;

    // Expected results and the edge that sampled each input
    logic [31:0] result_q [$];
    int unsigned edge_q [$];
    int unsigned cycle;

    fp_adder_top DUT (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .a         (a),
        .b         (b),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // Stimulus helpers
    //////////////////////////////////////////////////

    // Normal operand, exponent 1 to 254
    function automatic fp32_t rand_operand();
        fp32_t r;
        r.sign = 1'($urandom % 2);
        r.exp  = exp_t'(1 + $urandom % 254);
        r.frac = 23'($urandom);
        return r;
    endfunction

    // Random pair with directed corner cases mixed in
    task automatic make_pair(output fp32_t x, output fp32_t y);
        fp32_t t;
        x = rand_operand();
        y = rand_operand();
        case ($urandom % 16)
            // Carry out of equal exponents
            0: begin
                y.sign = x.sign;
                y.exp  = x.exp;
            end
            // Near cancellation, long left shift
            1: begin
                y      = x;
                y.sign = ~x.sign;
                y.frac = x.frac ^ 23'($urandom % 256);
            end
            // Exact cancellation
            2: begin
                y      = x;
                y.sign = ~x.sign;
            end
            // Smaller operand aligned away
            3: begin
                x.exp = exp_t'(40 + $urandom % 200);
                y.exp = x.exp - exp_t'(25 + $urandom % 15);
                if ($urandom % 2) begin
                    t = x;
                    x = y;
                    y = t;
                end
            end
            // Overflow to infinity
            4: begin
                x.exp  = 8'd254;
                y.exp  = 8'd253 + exp_t'($urandom % 2);
                y.sign = x.sign;
            end
            // Underflow to +0
            5: begin
                x.exp  = exp_t'(1 + $urandom % 3);
                y.exp  = x.exp;
                y.sign = ~x.sign;
                y.frac = x.frac ^ 23'($urandom % 4096);
            end
            default: begin
            end
        endcase
    endtask

    // Single comparison point for every check
    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("FAIL: time %0t: %s got %h expected %h", $time, what, got, expected);
            $display("TEST FAIL");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    //////////////////////////////////////////////////
    // Monitor and cycle limit
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [31:0] exp_result;
        int unsigned exp_edge;
        cycle++;
        if (cycle > MAX_CYCLES) begin
            $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end else if (out_valid === 1'b1) begin
            if (result_q.size() == 0) begin
                $display("Output valid at time %0t with no input outstanding", $time);
                $display("TEST FAIL");
                $fatal(1, "unexpected output");
            end else begin
                exp_result = result_q.pop_front();
                exp_edge   = edge_q.pop_front();
                check_value("result", result, exp_result);
                // Seen at this edge, three edges after its input was sampled
                check_value("output edge", 32'(cycle), 32'(exp_edge + 3));
            end
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        fp32_t op_a;
        fp32_t op_b;
        int    sent;
        rstn     = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        cycle    = 0;
        sent     = 0;
        void'($urandom(16));

        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;

        // Three of four cycles carry a pair
        while (sent < NUM_TXN) begin
            @(negedge clk);
            make_pair(op_a, op_b);
            a = op_a;
            b = op_b;
            if ($urandom % 4 != 0) begin
                in_valid = 1'b1;
                result_q.push_back(model_fp_add(op_a, op_b));
                edge_q.push_back(cycle + 1);
                sent++;
            end else begin
                in_valid = 1'b0;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;

        // Last result due three edges on, then idle a while for stray outputs
        repeat (8) @(negedge clk);

        if (result_q.size() == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("Expected results left over at the end of the run");
            $display("TEST FAIL");
            $fatal(1, "queue not empty");
        end
    end

endmodule

//--- verification/fp_adder_asserts.sv
`timescale 1ns/100ps

module fp_adder_asserts (
    input logic                    clk,
    input logic                    rstn,
    input logic                    sum_valid,
    input fp_add_pkg::shift_code_t shift_code,
    input logic                    out_valid
);

    import fp_add_pkg::*;

    // Encoder only emits left shifts, right shift or zero
    code_range: assert property (@(posedge clk) disable iff (!rstn)
        (shift_code <= 8'd23 || shift_code == SHIFT_RIGHT_CODE || shift_code == ZERO_CODE))
        else $error("shift code %0d out of range", shift_code);

    // Two-stage latency through normalization
    valid_latency: assert property (@(posedge clk) disable iff (!rstn)
        out_valid == $past(sum_valid, 2))
        else $error("out_valid does not follow interface valid by 2 cycles");

    // Reset holds the output idle
    reset_idle: assert property (@(posedge clk) !rstn |-> !out_valid)
        else $error("out_valid high during reset");

endmodule

bind fp_normalize fp_adder_asserts u_asserts (
    .clk        (clk),
    .rstn       (rstn),
    .sum_valid  (sum_in.valid),
    .shift_code (shift_code),
    .out_valid  (out_valid)
);

//--- verilog/fp_adder_top.sv
`timescale 1ns/100ps

module fp_adder_top (
    input  logic        clk,
    input  logic        rstn,
    input  logic        in_valid,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic        out_valid,
    output logic [31:0] result
);

    import fp_add_pkg::*;

    //////////////////////////////////////////////////
    // Add stage to normalization stage
    //////////////////////////////////////////////////

    // Aligned sum, one item per cycle at most
    fp_sum_if sum_bus ();

    // Align, order and add, 1 cycle
    fp_align_add u_align_add (
        .clk      (clk),
        .rstn     (rstn),
        .in_valid (in_valid),
        .a        (fp32_t'(a)),
        .b        (fp32_t'(b)),
        .sum_out  (sum_bus.producer)
    );

    // Encode, shift and pack, 2 cycles
    fp_normalize u_normalize (
        .clk       (clk),
        .rstn      (rstn),
        .sum_in    (sum_bus.consumer),
        .out_valid (out_valid),
        .result    (result)
    );

endmodule

//--- verilog/fp_normalize.sv
`timescale 1ns/100ps

module fp_normalize (
    input  logic        clk,
    input  logic        rstn,
    fp_sum_if.consumer  sum_in,
    output logic        out_valid,
    output logic [31:0] result
);

    import fp_add_pkg::*;

    // Leading one of the incoming sum, alone
    sum_t        lead_one;

    // Encoder outputs
    logic        code_valid;
    shift_code_t shift_code;

    // Payload delayed beside the encoder
    logic        sign_q;
    exp_t        exp_q;
    sum_t        sum_q;

    // Second stage
    logic [4:0]        lshift;
    sum_t              shifted;
    logic signed [9:0] exp_adj;
    fp32_t             result_d;

    //////////////////////////////////////////////////
    // Stage 1, leading one and encoder
    //////////////////////////////////////////////////

    // Highest set bit wins, later iterations override
    always_comb begin
        lead_one = '0;
        for (int i = 0; i < SUM_W; i++) begin
            if (sum_in.sum[i]) begin
                lead_one = sum_t'(1) << i;
            end
        end
    end

    fp_shift_encoder u_shift_encoder (
        .clk       (clk),
        .rstn      (rstn),
        .valid_in  (sum_in.valid),
        .in_data   (lead_one),
        .valid_out (code_valid),
        .out_data  (shift_code)
    );

    // Arrives together with the code
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sign_q <= 1'b0;
            exp_q  <= '0;
            sum_q  <= '0;
        end else if (sum_in.valid) begin
            sign_q <= sum_in.sign;
            exp_q  <= sum_in.exp;
            sum_q  <= sum_in.sum;
        end
    end

    //////////////////////////////////////////////////
    // Stage 2, shift, exponent limits, pack
    //////////////////////////////////////////////////

    // Left codes never exceed 23
    assign lshift = shift_code[4:0];

    always_comb begin
        shifted = '0;
        exp_adj = '0;
        if (shift_code == SHIFT_RIGHT_CODE) begin
            shifted = sum_q >> 1;
            exp_adj = $signed({2'b00, exp_q}) + 10'sd1;
        end else if (shift_code != ZERO_CODE) begin
            shifted = sum_q << lshift;
            exp_adj = $signed({2'b00, exp_q}) - $signed({2'b00, shift_code});
        end

        // Truncated fraction, hidden one sits at bit 23
        result_d = '{sign: sign_q, exp: exp_adj[7:0], frac: shifted[FRAC_W-1:0]};
        if (shift_code == ZERO_CODE || exp_adj <= 10'sd0) begin
            // Zero sum or underflow, flush to +0
            result_d = '0;
        end else if (exp_adj >= $signed({2'b00, EXP_MAX})) begin
            // Overflow, infinity with the kept sign
            result_d = '{sign: sign_q, exp: EXP_MAX, frac: '0};
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            out_valid <= 1'b0;
            result    <= '0;
        end else begin
            out_valid <= code_valid;
            if (code_valid) begin
                result <= result_d;
            end
        end
    end

endmodule

//--- verilog/fp_shift_encoder.sv
`timescale 1ns/100ps

module fp_shift_encoder (
    input  logic                    clk,
    input  logic                    rstn,
    input  logic                    valid_in,
    input  fp_add_pkg::sum_t        in_data,
    output logic                    valid_out,
    output fp_add_pkg::shift_code_t out_data
);

    import fp_add_pkg::*;

    // Code for the current word
    shift_code_t code_d;

    //////////////////////////////////////////////////
    // One-hot to shift code
    //////////////////////////////////////////////////

    // Bit k below the carry gives a left shift of 23 - k
    // Carry bit gives a right shift by one
    // Anything else, which is only zero here, gives the zero code
    always_comb begin
        code_d = ZERO_CODE;
        for (int k = 0; k < SUM_W - 1; k++) begin
            if (in_data == (sum_t'(1) << k)) begin
                code_d = shift_code_t'(SUM_W - 2 - k);
            end
        end
        if (in_data == (sum_t'(1) << (SUM_W - 1))) begin
            code_d = SHIFT_RIGHT_CODE;
        end
    end

    //////////////////////////////////////////////////
    // Output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_out <= 1'b0;
            out_data  <= '0;
        end else begin
            valid_out <= valid_in;
            // Code holds while idle
            if (valid_in) begin
                out_data <= code_d;
            end
        end
    end

endmodule

//--- verilog/fp_align_add.sv
`timescale 1ns/100ps

module fp_align_add (
    input  logic              clk,
    input  logic              rstn,
    input  logic              in_valid,
    input  fp_add_pkg::fp32_t a,
    input  fp_add_pkg::fp32_t b,
    fp_sum_if.producer        sum_out
);

    import fp_add_pkg::*;

    //////////////////////////////////////////////////
    // Unpack
    //////////////////////////////////////////////////

    // Mantissas with hidden one
    logic [MANT_W-1:0] mant_a;
    logic [MANT_W-1:0] mant_b;

    // Larger operand by exponent, then mantissa
    logic              a_is_big;

    logic              big_sign;
    exp_t              big_exp;
    logic [MANT_W-1:0] big_mant;
    logic              small_sign;
    exp_t              small_exp;
    logic [MANT_W-1:0] small_mant;

    // Alignment
    exp_t              exp_diff;
    logic [MANT_W-1:0] small_aligned;

    // Sum before the register
    sum_t              sum_d;

    // Exponent 0 counts as zero, subnormals included
    always_comb begin
        mant_a = (a.exp != '0) ? {1'b1, a.frac} : '0;
        mant_b = (b.exp != '0) ? {1'b1, b.frac} : '0;
    end

    //////////////////////////////////////////////////
    // Order by magnitude
    //////////////////////////////////////////////////

    // Exponent above mantissa gives a plain magnitude compare
    assign a_is_big = ({a.exp, mant_a} >= {b.exp, mant_b});

    always_comb begin
        if (a_is_big) begin
            big_sign   = a.sign;
            big_exp    = a.exp;
            big_mant   = mant_a;
            small_sign = b.sign;
            small_exp  = b.exp;
            small_mant = mant_b;
        end else begin
            big_sign   = b.sign;
            big_exp    = b.exp;
            big_mant   = mant_b;
            small_sign = a.sign;
            small_exp  = a.exp;
            small_mant = mant_a;
        end
    end

    //////////////////////////////////////////////////
    // Align and add
    //////////////////////////////////////////////////

    // Never negative after ordering
    assign exp_diff = big_exp - small_exp;

    // Shifted-out bits are dropped, no sticky
    always_comb begin
        if (exp_diff >= exp_t'(SUM_W)) begin
            small_aligned = '0;
        end else begin
            small_aligned = small_mant >> exp_diff;
        end
    end

    // Same signs add, otherwise subtract the smaller
    always_comb begin
        if (big_sign == small_sign) begin
            sum_d = {1'b0, big_mant} + {1'b0, small_aligned};
        end else begin
            sum_d = {1'b0, big_mant} - {1'b0, small_aligned};
        end
    end

    //////////////////////////////////////////////////
    // Stage register onto the interface
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            sum_out.valid <= 1'b0;
            sum_out.sign  <= 1'b0;
            sum_out.exp   <= '0;
            sum_out.sum   <= '0;
        end else begin
            sum_out.valid <= in_valid;
            // Payload only moves with a valid pair
            if (in_valid) begin
                sum_out.sign <= big_sign;
                sum_out.exp  <= big_exp;
                sum_out.sum  <= sum_d;
            end
        end
    end

endmodule

//--- verilog/fp_sum_if.sv
`timescale 1ns/100ps

interface fp_sum_if;

    import fp_add_pkg::*;

    // Qualifies the other fields
    logic valid;
    // Sign of the larger operand
    logic sign;
    // Exponent of the larger operand
    exp_t exp;
    // Aligned magnitude sum
    sum_t sum;

    // Add stage side
    modport producer (
        output valid,
        output sign,
        output exp,
        output sum
    );

    // Normalization side, takes every valid item
    modport consumer (
        input valid,
        input sign,
        input exp,
        input sum
    );

endinterface

//--- verilog/fp_add_pkg.sv
package fp_add_pkg;

    //////////////////////////////////////////////////
    // FP32 field widths
    //////////////////////////////////////////////////

    localparam int FRAC_W = 23;
    // Hidden one plus fraction
    localparam int MANT_W = FRAC_W + 1;
    // Mantissa plus carry bit
    localparam int SUM_W  = MANT_W + 1;

    // Biased exponent
    typedef logic [7:0] exp_t;

    // Single-precision word, sign in the top bit
    typedef struct packed {
        logic              sign;
        exp_t              exp;
        logic [FRAC_W-1:0] frac;
    } fp32_t;

    // Magnitude sum, bit 24 is the carry
    typedef logic [SUM_W-1:0] sum_t;

    //////////////////////////////////////////////////
    // Shift encoder codes
    //////////////////////////////////////////////////

    // 0 to 23 is a left shift by that many places
    typedef logic [7:0] shift_code_t;

    // Carry set, shift right by one
    localparam shift_code_t SHIFT_RIGHT_CODE = 8'h80;
    // Sum is zero
    localparam shift_code_t ZERO_CODE        = 8'd40;

    // Exponent reserved for infinity
    localparam exp_t EXP_MAX = 8'd255;

endpackage
